// ==== src.f ====
source/regfile_pkg.sv
source/bank_wr_if.sv
source/bank_ram_3r1w.sv
source/bank_write_steer.sv
source/bank_clear_seq.sv
source/bank_mpregfiles_4r2w.sv
source/regfile_top.sv
test/regfile_properties.sv
test/tb_regfile.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the register file testbench with Verilator and runs it.
# The exit status is non-zero when the build or the simulation fails.

cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -Wno-fatal \
        -f src.f \
        --top-module tb_regfile \
        -o tb_regfile \
    && ./obj_dir/tb_regfile \
    || { echo "Build or simulation failed."; exit 1; }

// ==== test/tb_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_regfile;

    localparam int CLK_PERIOD      = 8;
    localparam int RESET_CYCLES    = 8;
    localparam int RANDOM_CYCLES   = 500;
    localparam int WATCHDOG_CYCLES = 2 * (RANDOM_CYCLES + 500); // Twice the expected run.
    localparam logic [31:0] RANDOM_SEED = 32'hf80f17a7;

    logic clk;
    logic RESET_NEED;
    regfile_pkg::reg_addr_t ra0, ra1, ra2, ra3;
    regfile_pkg::reg_data_t rd0, rd1, rd2, rd3;
    regfile_pkg::reg_addr_t wa0, wa1;
    regfile_pkg::reg_data_t wd0, wd1;
    logic we0, we1;
    logic conflict;
    logic ready;

    regfile_pkg::reg_data_t model [32]; // Expected register contents.
    logic clearing;
    int clear_idx;
    string test_name;

    regfile_top UUT (
        .clk (clk), .RESET_NEED (RESET_NEED),
        .ra0_i (ra0), .ra1_i (ra1), .ra2_i (ra2), .ra3_i (ra3),
        .rd0_o (rd0), .rd1_o (rd1), .rd2_o (rd2), .rd3_o (rd3),
        .wa0_i (wa0), .wa1_i (wa1), .wd0_i (wd0), .wd1_i (wd1),
        .we0_i (we0), .we1_i (we1),
        .conflict_o (conflict), .ready_o (ready)
    );

    bind regfile_top regfile_properties u_properties (
        .clk (clk), .RESET_NEED (RESET_NEED), .ready_i (ready_o), .conflict_i (conflict_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic expected_conflict(logic rdy, logic e0, logic e1,
                                               regfile_pkg::reg_addr_t a0,
                                               regfile_pkg::reg_addr_t a1);
        return rdy && e0 && e1 && (a0[0] == a1[0]); // Same bank, port 1 loses.
    endfunction

    function automatic regfile_pkg::reg_data_t next_value(
        int r, regfile_pkg::reg_data_t old_value,
        regfile_pkg::reg_addr_t a0, regfile_pkg::reg_data_t d0, logic e0,
        regfile_pkg::reg_addr_t a1, regfile_pkg::reg_data_t d1, logic e1);
        logic lost;
        lost = expected_conflict(1'b1, e0, e1, a0, a1);
        if (e0 && (int'(a0) == r)) begin
            return d0;
        end
        if (e1 && !lost && (int'(a1) == r)) begin
            return d1;
        end
        return old_value;
    endfunction

    task automatic compare_data(string what, regfile_pkg::reg_data_t expected,
                                regfile_pkg::reg_data_t actual);
        if (actual !== expected) begin
            $display("FAIL %s %s expected %h actual %h", test_name, what, expected, actual);
            $display("TESTBENCH FAILED");
            $fatal(1, "Read data mismatch.");
        end
    endtask

    task automatic compare_bit(string what, logic expected, logic actual);
        if (actual !== expected) begin
            $display("FAIL %s %s expected %b actual %b", test_name, what, expected, actual);
            $display("TESTBENCH FAILED");
            $fatal(1, "Status mismatch.");
        end
    endtask

    // Checks one cycle, then applies what the coming rising edge commits.
    task automatic check_cycle();
        regfile_pkg::reg_addr_t addr [4];
        regfile_pkg::reg_data_t data [4];
        logic exp_ready;
        logic exp_conflict;
        addr = '{ra0, ra1, ra2, ra3};
        data = '{rd0, rd1, rd2, rd3};
        exp_ready = !clearing;
        exp_conflict = expected_conflict(exp_ready, we0, we1, wa0, wa1);
        compare_bit("ready_o", exp_ready, ready);
        compare_bit("conflict_o", exp_conflict, conflict);
        if (exp_ready) begin
            for (int p = 0; p < 4; p++) begin
                compare_data($sformatf("rd%0d_o of x%0d", p, addr[p]), model[addr[p]], data[p]);
            end
        end
        if (RESET_NEED) begin
            clearing = 1'b1;
            clear_idx = 0;
        end else if (clearing) begin
            model[2 * clear_idx] = '0; // Word k of both banks.
            model[2 * clear_idx + 1] = '0;
            if (clear_idx == regfile_pkg::CLEAR_CYCLES - 1) begin
                clearing = 1'b0;
            end
            clear_idx++;
        end else begin
            for (int r = 0; r < 32; r++) begin
                model[r] = next_value(r, model[r], wa0, wd0, we0, wa1, wd1, we1);
            end
        end
    endtask

    initial begin : compare_outputs
        clearing = 1'b1;
        clear_idx = 0;
        for (int r = 0; r < 32; r++) begin
            model[r] = '0;
        end
        forever begin
            @(negedge clk);
            #(CLK_PERIOD / 2 - 1); // Just before the rising edge.
            check_cycle();
        end
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the tests did not finish within %0d cycles.", WATCHDOG_CYCLES);
        $display("TESTBENCH FAILED");
        $fatal(1, "Watchdog expired.");
    end

    task automatic set_writes(regfile_pkg::reg_addr_t a0, regfile_pkg::reg_data_t d0, logic e0,
                              regfile_pkg::reg_addr_t a1, regfile_pkg::reg_data_t d1, logic e1);
        wa0 = a0;
        wd0 = d0;
        we0 = e0;
        wa1 = a1;
        wd1 = d1;
        we1 = e1;
    endtask

    task automatic set_reads(regfile_pkg::reg_addr_t a0, regfile_pkg::reg_addr_t a1,
                             regfile_pkg::reg_addr_t a2, regfile_pkg::reg_addr_t a3);
        ra0 = a0;
        ra1 = a1;
        ra2 = a2;
        ra3 = a3;
    endtask

    task automatic random_cycle();
        @(negedge clk);
        set_reads(5'($urandom), 5'($urandom), 5'($urandom), 5'($urandom));
        set_writes(5'($urandom), $urandom, 1'($urandom), 5'($urandom), $urandom, 1'($urandom));
    endtask

    // Every port sees every register once over 32 cycles.
    task automatic read_all();
        for (int i = 0; i < 32; i++) begin
            @(negedge clk);
            set_writes('0, '0, 1'b0, '0, '0, 1'b0);
            set_reads(5'(i), 5'(i + 8), 5'(i + 16), 5'(i + 24));
        end
    endtask

    task automatic write_then_read(regfile_pkg::reg_addr_t a0, logic e0,
                                   regfile_pkg::reg_addr_t a1, logic e1);
        @(negedge clk);
        set_writes(a0, $urandom, e0, a1, $urandom, e1);
        set_reads(a0, a1, a1, a0); // Same cycle still shows the old values.
        @(negedge clk);
        set_writes('0, '0, 1'b0, '0, '0, 1'b0);
    endtask

    initial begin : stimulus
        regfile_pkg::reg_addr_t r0;
        regfile_pkg::reg_addr_t r1;
        void'($urandom(RANDOM_SEED));
        RESET_NEED = 1'b1;
        set_reads('0, '0, '0, '0);
        set_writes('0, '0, 1'b0, '0, '0, 1'b0);
        test_name = "reset_and_clear";
        repeat (RESET_CYCLES) @(negedge clk);
        RESET_NEED = 1'b0;
        while (ready !== 1'b1) @(negedge clk);

        test_name = "clear_readback";
        read_all();

        test_name = "single_write";
        for (int n = 0; n < 24; n++) begin
            r0 = 5'($urandom);
            write_then_read(r0, !n[0], r0, n[0]);
        end

        test_name = "dual_write_split";
        for (int n = 0; n < 16; n++) begin
            r0 = 5'($urandom);
            r1 = {4'($urandom), ~r0[0]};
            write_then_read(r0, 1'b1, r1, 1'b1);
        end

        test_name = "dual_write_conflict";
        for (int n = 0; n < 16; n++) begin
            r0 = 5'($urandom);
            r1 = {4'($urandom), r0[0]};
            write_then_read(r0, 1'b1, r1, 1'b1);
        end

        test_name = "mid_run_reset";
        repeat (8) random_cycle();
        RESET_NEED = 1'b1;
        repeat (4) random_cycle();
        RESET_NEED = 1'b0;
        do random_cycle(); while (ready !== 1'b1);
        read_all();

        test_name = "random_mix";
        repeat (RANDOM_CYCLES) random_cycle();
        @(negedge clk);
        set_writes('0, '0, 1'b0, '0, '0, 1'b0);
        repeat (2) @(negedge clk);
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/regfile_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module regfile_properties (
    input wire clk,
    input wire RESET_NEED,
    input wire ready_i,
    input wire conflict_i
);

    logic [4:0] low_cycles; // Cycles with ready low since reset was released.

    always_ff @(posedge clk) begin
        if (RESET_NEED) begin
            low_cycles <= '0;
        end else if (!ready_i && (low_cycles != 5'd31)) begin
            low_cycles <= low_cycles + 5'd1;
        end
    end

    conflict_needs_ready: assert property (@(posedge clk) conflict_i |-> ready_i)
        else $error("conflict_o was high while ready_o was low.");

    // The clear walk must have run its full length before ready rises.
    ready_after_clear: assert property (
        @(posedge clk) disable iff (RESET_NEED)
        $rose(ready_i) |-> (low_cycles == regfile_pkg::CLEAR_CYCLES))
        else $error("ready_o rose after %0d low cycles.", low_cycles);

    reset_forces_not_ready: assert property (@(posedge clk) RESET_NEED |=> !ready_i)
        else $error("ready_o was high in the cycle after a reset edge.");

endmodule

`default_nettype wire

// ==== source/regfile_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module regfile_top (
    input  wire                    clk,
    input  wire                    RESET_NEED,

    // Read ports, combinational.
    input  regfile_pkg::reg_addr_t ra0_i,
    input  regfile_pkg::reg_addr_t ra1_i,
    input  regfile_pkg::reg_addr_t ra2_i,
    input  regfile_pkg::reg_addr_t ra3_i,
    output regfile_pkg::reg_data_t rd0_o,
    output regfile_pkg::reg_data_t rd1_o,
    output regfile_pkg::reg_data_t rd2_o,
    output regfile_pkg::reg_data_t rd3_o,

    // Write ports, committed at the rising edge.
    input  regfile_pkg::reg_addr_t wa0_i,
    input  regfile_pkg::reg_addr_t wa1_i,
    input  regfile_pkg::reg_data_t wd0_i,
    input  regfile_pkg::reg_data_t wd1_i,
    input  wire                    we0_i,
    input  wire                    we1_i,

    output logic                   conflict_o, // Port 1 was dropped this cycle.
    output logic                   ready_o
);

    bank_mpregfiles_4r2w u_core (
        .clk        (clk),
        .RESET_NEED (RESET_NEED),

        .ra0_i      (ra0_i),
        .ra1_i      (ra1_i),
        .ra2_i      (ra2_i),
        .ra3_i      (ra3_i),
        .rd0_o      (rd0_o),
        .rd1_o      (rd1_o),
        .rd2_o      (rd2_o),
        .rd3_o      (rd3_o),

        .wa0_i      (wa0_i),
        .wa1_i      (wa1_i),
        .wd0_i      (wd0_i),
        .wd1_i      (wd1_i),
        .we0_i      (we0_i),
        .we1_i      (we1_i),

        .conflict_o (conflict_o),
        .ready_o    (ready_o)
    );

endmodule

`default_nettype wire

// ==== source/bank_mpregfiles_4r2w.sv ====
`timescale 1ns/1ps
`default_nettype none

module bank_mpregfiles_4r2w (
    input  wire                    clk,
    input  wire                    RESET_NEED,

    input  regfile_pkg::reg_addr_t ra0_i,
    input  regfile_pkg::reg_addr_t ra1_i,
    input  regfile_pkg::reg_addr_t ra2_i,
    input  regfile_pkg::reg_addr_t ra3_i,
    output regfile_pkg::reg_data_t rd0_o,
    output regfile_pkg::reg_data_t rd1_o,
    output regfile_pkg::reg_data_t rd2_o,
    output regfile_pkg::reg_data_t rd3_o,

    input  regfile_pkg::reg_addr_t wa0_i,
    input  regfile_pkg::reg_addr_t wa1_i,
    input  regfile_pkg::reg_data_t wd0_i,
    input  regfile_pkg::reg_data_t wd1_i,
    input  wire                    we0_i,
    input  wire                    we1_i,

    output logic                   conflict_o,
    output logic                   ready_o
);

    logic                    clr_active;
    regfile_pkg::bank_addr_t clr_index;
    logic                    b0_we;
    logic                    b1_we;

    regfile_pkg::reg_data_t b0_rd0, b0_rd1, b0_rd2, b0_rd3;
    regfile_pkg::reg_data_t b1_rd0, b1_rd1, b1_rd2, b1_rd3;

    bank_wr_if wr ();

    bank_clear_seq u_clear (
        .clk          (clk),
        .RESET_NEED   (RESET_NEED),
        .clr_active_o (clr_active),
        .clr_index_o  (clr_index)
    );

    bank_write_steer u_steer (
        .wa0_i        (wa0_i),
        .wa1_i        (wa1_i),
        .wd0_i        (wd0_i),
        .wd1_i        (wd1_i),
        .we0_i        (we0_i),
        .we1_i        (we1_i),
        .clr_active_i (clr_active),
        .clr_index_i  (clr_index),
        .conflict_o   (conflict_o),
        .wr           (wr.steer)
    );

    // The clear flag is already set while reset is high, so hold the RAMs off.
    assign b0_we = wr.b0_we && !RESET_NEED;
    assign b1_we = wr.b1_we && !RESET_NEED;

    // Even registers. The second copy only serves read port 3.
    bank_ram_3r1w u_b0_ram0 (
        .clk (clk),
        .raddr0_i (ra0_i[regfile_pkg::ADDR_W-1:1]), .rdata0_o (b0_rd0),
        .raddr1_i (ra1_i[regfile_pkg::ADDR_W-1:1]), .rdata1_o (b0_rd1),
        .raddr2_i (ra2_i[regfile_pkg::ADDR_W-1:1]), .rdata2_o (b0_rd2),
        .waddr_i (wr.b0_addr), .wdata_i (wr.b0_data), .we_i (b0_we)
    );
    bank_ram_3r1w u_b0_ram1 (
        .clk (clk),
        .raddr0_i (ra3_i[regfile_pkg::ADDR_W-1:1]), .rdata0_o (b0_rd3),
        .raddr1_i ('0), .rdata1_o (),
        .raddr2_i ('0), .rdata2_o (),
        .waddr_i (wr.b0_addr), .wdata_i (wr.b0_data), .we_i (b0_we)
    );

    // Odd registers.
    bank_ram_3r1w u_b1_ram0 (
        .clk (clk),
        .raddr0_i (ra0_i[regfile_pkg::ADDR_W-1:1]), .rdata0_o (b1_rd0),
        .raddr1_i (ra1_i[regfile_pkg::ADDR_W-1:1]), .rdata1_o (b1_rd1),
        .raddr2_i (ra2_i[regfile_pkg::ADDR_W-1:1]), .rdata2_o (b1_rd2),
        .waddr_i (wr.b1_addr), .wdata_i (wr.b1_data), .we_i (b1_we)
    );
    bank_ram_3r1w u_b1_ram1 (
        .clk (clk),
        .raddr0_i (ra3_i[regfile_pkg::ADDR_W-1:1]), .rdata0_o (b1_rd3),
        .raddr1_i ('0), .rdata1_o (),
        .raddr2_i ('0), .rdata2_o (),
        .waddr_i (wr.b1_addr), .wdata_i (wr.b1_data), .we_i (b1_we)
    );

    assign rd0_o = ra0_i[0] ? b1_rd0 : b0_rd0; // Bank select on the low bit.
    assign rd1_o = ra1_i[0] ? b1_rd1 : b0_rd1;
    assign rd2_o = ra2_i[0] ? b1_rd2 : b0_rd2;
    assign rd3_o = ra3_i[0] ? b1_rd3 : b0_rd3;

    assign ready_o = !clr_active;

endmodule

`default_nettype wire

// ==== source/bank_clear_seq.sv ====
`timescale 1ns/1ps
`default_nettype none

module bank_clear_seq (
    input  wire                     clk,
    input  wire                     RESET_NEED,
    output logic                    clr_active_o,
    output regfile_pkg::bank_addr_t clr_index_o
);

    logic                    active_q;
    regfile_pkg::bank_addr_t index_q;

    // One word per bank per cycle, so the walk takes CLEAR_CYCLES cycles.
    always_ff @(posedge clk) begin
        if (RESET_NEED) begin
            active_q <= 1'b1;
            index_q  <= '0;
        end else if (active_q) begin
            index_q <= index_q + 1'b1;
            if (index_q == regfile_pkg::bank_addr_t'(regfile_pkg::CLEAR_CYCLES - 1)) begin
                active_q <= 1'b0; // Last word written this cycle.
            end
        end
    end

    assign clr_active_o = active_q;
    assign clr_index_o  = index_q;

endmodule

`default_nettype wire

// ==== source/bank_write_steer.sv ====
`timescale 1ns/1ps
`default_nettype none

module bank_write_steer (
    input  regfile_pkg::reg_addr_t  wa0_i,
    input  regfile_pkg::reg_addr_t  wa1_i,
    input  regfile_pkg::reg_data_t  wd0_i,
    input  regfile_pkg::reg_data_t  wd1_i,
    input  wire                     we0_i,
    input  wire                     we1_i,

    input  wire                     clr_active_i,
    input  regfile_pkg::bank_addr_t clr_index_i,

    output logic                    conflict_o,
    bank_wr_if.steer                wr
);

    logic p0_b0; // Port 0 writes an even register.
    logic p1_b0;
    logic p0_b1;
    logic p1_b1;

    assign p0_b0 = we0_i && (wa0_i[0] == 1'b0);
    assign p1_b0 = we1_i && (wa1_i[0] == 1'b0);
    assign p0_b1 = we0_i && (wa0_i[0] == 1'b1);
    assign p1_b1 = we1_i && (wa1_i[0] == 1'b1);

    assign conflict_o = !clr_active_i && we0_i && we1_i && (wa0_i[0] == wa1_i[0]);

    always_comb begin
        if (clr_active_i) begin
            wr.b0_addr = clr_index_i; // Zero-fill owns both banks.
            wr.b0_data = '0;
            wr.b0_we   = 1'b1;
            wr.b1_addr = clr_index_i;
            wr.b1_data = '0;
            wr.b1_we   = 1'b1;
        end else begin
            wr.b0_we = p0_b0 || p1_b0;
            wr.b1_we = p0_b1 || p1_b1;
            if (p0_b0) begin
                wr.b0_addr = wa0_i[regfile_pkg::ADDR_W-1:1]; // Port 0 has priority.
                wr.b0_data = wd0_i;
            end else begin
                wr.b0_addr = wa1_i[regfile_pkg::ADDR_W-1:1];
                wr.b0_data = wd1_i;
            end
            if (p0_b1) begin
                wr.b1_addr = wa0_i[regfile_pkg::ADDR_W-1:1];
                wr.b1_data = wd0_i;
            end else begin
                wr.b1_addr = wa1_i[regfile_pkg::ADDR_W-1:1];
                wr.b1_data = wd1_i;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/bank_ram_3r1w.sv ====
`timescale 1ns/1ps
`default_nettype none

module bank_ram_3r1w (
    input  wire                     clk,

    input  regfile_pkg::bank_addr_t raddr0_i,
    input  regfile_pkg::bank_addr_t raddr1_i,
    input  regfile_pkg::bank_addr_t raddr2_i,
    output regfile_pkg::reg_data_t  rdata0_o,
    output regfile_pkg::reg_data_t  rdata1_o,
    output regfile_pkg::reg_data_t  rdata2_o,

    input  regfile_pkg::bank_addr_t waddr_i,
    input  regfile_pkg::reg_data_t  wdata_i,
    input  wire                     we_i
);

    regfile_pkg::reg_data_t mem [regfile_pkg::BANK_DEPTH];

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
    end

    // Reads see the old word during a write to the same index.
    assign rdata0_o = mem[raddr0_i];
    assign rdata1_o = mem[raddr1_i];
    assign rdata2_o = mem[raddr2_i];

endmodule

`default_nettype wire

// ==== source/bank_wr_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// Steered write of both banks. A write with its enable high is committed at
// the next rising clock edge, and there is no handshake.
interface bank_wr_if;

    regfile_pkg::bank_addr_t b0_addr; // Word index inside bank 0.
    regfile_pkg::reg_data_t  b0_data;
    logic                    b0_we;

    regfile_pkg::bank_addr_t b1_addr; // Word index inside bank 1.
    regfile_pkg::reg_data_t  b1_data;
    logic                    b1_we;

    // Driven by the write steer.
    modport steer (
        output b0_addr,
        output b0_data,
        output b0_we,
        output b1_addr,
        output b1_data,
        output b1_we
    );

    // Read by the RAM write ports.
    modport bank (
        input b0_addr,
        input b0_data,
        input b0_we,
        input b1_addr,
        input b1_data,
        input b1_we
    );

endinterface

`default_nettype wire

// ==== source/regfile_pkg.sv ====
`default_nettype none

package regfile_pkg;

    localparam int DATA_W = 32;
    localparam int ADDR_W = 5;

    // Words per bank; the low address bit picks the bank.
    localparam int BANK_DEPTH = 16;

    localparam int CLEAR_CYCLES = BANK_DEPTH; // Both banks are cleared in parallel.

    // Architectural register number.
    typedef logic [ADDR_W-1:0] reg_addr_t;

    typedef logic [DATA_W-1:0] reg_data_t;

    // Register number with its bank bit stripped.
    typedef logic [ADDR_W-2:0] bank_addr_t;

endpackage

`default_nettype wire
